// File: mini_core_pkg.sv
// Shared types for the mini core
// Word, register index and retire order widths, ALU and fetch enums,
// and the packets passed between pipeline stages

package mini_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [15:0] order_t;

  // Operations the execute stage understands
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_IMM
  } alu_op_e;

  // APB requester phases
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_SETUP,
    FETCH_ACCESS
  } fetch_state_e;

  // Fetch to decode
  typedef struct packed {
    word_t pc;
    word_t insn;
    logic  fetch_err;
  } fetch_pkt_t;

  // Decode to execute
  typedef struct packed {
    word_t     pc;
    word_t     insn;
    alu_op_e   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_imm;
    word_t     imm;
    logic      illegal;
    logic      fetch_err;
  } dec_pkt_t;

  // One retired instruction, RVFI style
  typedef struct packed {
    order_t    order;
    word_t     pc;
    word_t     insn;
    reg_addr_t rd_addr;
    word_t     rd_wdata;
    logic      trap;
  } retire_t;

endpackage

// File: core_fetch.sv
// Instruction fetch stage
// APB read requester with pc register and fetch packet output

module core_fetch #(
  parameter mini_core_pkg::word_t BootAddr = 32'h0000_0000
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       fetch_enable_i,

  output logic                       psel_o,
  output logic                       penable_o,
  output mini_core_pkg::word_t       paddr_o,
  input  mini_core_pkg::word_t       prdata_i,
  input  logic                       pready_i,
  input  logic                       pslverr_i,

  output logic                       fetch_valid_o,
  output mini_core_pkg::fetch_pkt_t  fetch_o
);

  mini_core_pkg::fetch_state_e state_q, state_d;
  mini_core_pkg::word_t        pc_q;
  mini_core_pkg::fetch_pkt_t   fetch_q;
  logic                        fetch_valid_q;
  logic                        xfer_done;

  // Transfer ends when the slave is ready in the access phase
  assign xfer_done = (state_q == mini_core_pkg::FETCH_ACCESS) && pready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mini_core_pkg::FETCH_IDLE: begin
        if (fetch_enable_i) begin
          state_d = mini_core_pkg::FETCH_SETUP;
        end
      end
      mini_core_pkg::FETCH_SETUP: begin
        state_d = mini_core_pkg::FETCH_ACCESS;
      end
      mini_core_pkg::FETCH_ACCESS: begin
        // Go straight to the next setup phase if still enabled
        if (pready_i) begin
          state_d = fetch_enable_i ? mini_core_pkg::FETCH_SETUP : mini_core_pkg::FETCH_IDLE;
        end
      end
      default: begin
        state_d = mini_core_pkg::FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= mini_core_pkg::FETCH_IDLE;
      pc_q          <= BootAddr;
      fetch_valid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      fetch_valid_q <= xfer_done;
      if (xfer_done) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // Packet payload, captured on the completion edge
  always_ff @(posedge clk_i) begin
    if (xfer_done) begin
      fetch_q.pc        <= pc_q;
      fetch_q.insn      <= prdata_i;
      fetch_q.fetch_err <= pslverr_i;
    end
  end

  assign psel_o        = (state_q != mini_core_pkg::FETCH_IDLE);
  assign penable_o     = (state_q == mini_core_pkg::FETCH_ACCESS);
  assign paddr_o       = pc_q;
  assign fetch_valid_o = fetch_valid_q;
  assign fetch_o       = fetch_q;

endmodule

// File: core_decode.sv
// Decode stage
// Field extraction, immediates and illegal word detection for the RV32I subset

module core_decode (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       fetch_valid_i,
  input  mini_core_pkg::fetch_pkt_t  fetch_i,
  output logic                       dec_valid_o,
  output mini_core_pkg::dec_pkt_t    dec_o
);

  localparam logic [6:0] OpcOp    = 7'b0110011;
  localparam logic [6:0] OpcOpImm = 7'b0010011;
  localparam logic [6:0] OpcLui   = 7'b0110111;

  mini_core_pkg::word_t    insn;
  mini_core_pkg::dec_pkt_t dec_d;
  mini_core_pkg::dec_pkt_t dec_q;
  logic                    dec_valid_q;
  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;

  assign insn   = fetch_i.insn;
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  always_comb begin
    dec_d           = '0;
    dec_d.pc        = fetch_i.pc;
    dec_d.insn      = insn;
    dec_d.fetch_err = fetch_i.fetch_err;
    dec_d.rd        = insn[11:7];
    dec_d.rs1       = insn[19:15];
    dec_d.rs2       = insn[24:20];
    dec_d.op        = mini_core_pkg::ALU_ADD;
    // Sign-extended I-immediate unless LUI overrides it
    dec_d.imm       = {{20{insn[31]}}, insn[31:20]};
    dec_d.illegal   = 1'b0;

    case (opcode)
      OpcOp: begin
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec_d.op = mini_core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: dec_d.op = mini_core_pkg::ALU_SUB;
          {7'b0000000, 3'b111}: dec_d.op = mini_core_pkg::ALU_AND;
          {7'b0000000, 3'b110}: dec_d.op = mini_core_pkg::ALU_OR;
          {7'b0000000, 3'b100}: dec_d.op = mini_core_pkg::ALU_XOR;
          default:              dec_d.illegal = 1'b1;
        endcase
      end
      OpcOpImm: begin
        dec_d.use_imm = 1'b1;
        case (funct3)
          3'b000:  dec_d.op = mini_core_pkg::ALU_ADD;
          3'b111:  dec_d.op = mini_core_pkg::ALU_AND;
          3'b110:  dec_d.op = mini_core_pkg::ALU_OR;
          3'b100:  dec_d.op = mini_core_pkg::ALU_XOR;
          default: dec_d.illegal = 1'b1;
        endcase
      end
      OpcLui: begin
        dec_d.use_imm = 1'b1;
        dec_d.op      = mini_core_pkg::ALU_PASS_IMM;
        dec_d.imm     = {insn[31:12], 12'h000};
      end
      default: begin
        dec_d.illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= fetch_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      dec_q <= dec_d;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_o       = dec_q;

endmodule

// File: core_execute.sv
// Execute and writeback stage
// Register file, ALU, retire record with order counter, trap alert

module core_execute (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      dec_valid_i,
  input  mini_core_pkg::dec_pkt_t   dec_i,
  output logic                      retire_valid_o,
  output mini_core_pkg::retire_t    retire_o,
  output logic                      alert_o
);

  mini_core_pkg::word_t   rf_q [32];
  mini_core_pkg::word_t   rs1_data;
  mini_core_pkg::word_t   rs2_data;
  mini_core_pkg::word_t   op_b;
  mini_core_pkg::word_t   alu_res;
  mini_core_pkg::order_t  order_q;
  mini_core_pkg::retire_t retire_d;
  mini_core_pkg::retire_t retire_q;
  logic                   retire_valid_q;
  logic                   alert_q;
  logic                   trap;
  logic                   rf_we;

  // x0 is never written, so it reads as zero after reset
  assign rs1_data = rf_q[dec_i.rs1];
  assign rs2_data = rf_q[dec_i.rs2];
  assign op_b     = dec_i.use_imm ? dec_i.imm : rs2_data;

  always_comb begin
    case (dec_i.op)
      mini_core_pkg::ALU_ADD:      alu_res = rs1_data + op_b;
      mini_core_pkg::ALU_SUB:      alu_res = rs1_data - op_b;
      mini_core_pkg::ALU_AND:      alu_res = rs1_data & op_b;
      mini_core_pkg::ALU_OR:       alu_res = rs1_data | op_b;
      mini_core_pkg::ALU_XOR:      alu_res = rs1_data ^ op_b;
      mini_core_pkg::ALU_PASS_IMM: alu_res = dec_i.imm;
      default:                     alu_res = '0;
    endcase
  end

  assign trap  = dec_i.illegal | dec_i.fetch_err;
  assign rf_we = dec_valid_i && !trap && (dec_i.rd != '0);

  // Trap records and x0 writes report zero in rd fields
  always_comb begin
    retire_d.order    = order_q;
    retire_d.pc       = dec_i.pc;
    retire_d.insn     = dec_i.insn;
    retire_d.trap     = trap;
    retire_d.rd_addr  = trap ? '0 : dec_i.rd;
    retire_d.rd_wdata = (trap || dec_i.rd == '0) ? '0 : alu_res;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        rf_q[i] <= '0;
      end
    end else if (rf_we) begin
      rf_q[dec_i.rd] <= alu_res;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      order_q        <= '0;
      retire_valid_q <= 1'b0;
      alert_q        <= 1'b0;
    end else begin
      retire_valid_q <= dec_valid_i;
      alert_q        <= dec_valid_i && trap;
      if (dec_valid_i) begin
        order_q <= order_q + 16'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      retire_q <= retire_d;
    end
  end

  assign retire_valid_o = retire_valid_q;
  assign retire_o       = retire_q;
  assign alert_o        = alert_q;

endmodule

// File: mini_core_top.sv
// Mini core top level
// Fetch, decode and execute stages with APB, trace and alert ports

module mini_core_top #(
  parameter mini_core_pkg::word_t BootAddr = 32'h0000_0000
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    fetch_enable_i,

  output logic                    psel_o,
  output logic                    penable_o,
  output mini_core_pkg::word_t    paddr_o,
  input  mini_core_pkg::word_t    prdata_i,
  input  logic                    pready_i,
  input  logic                    pslverr_i,

  output logic                    retire_valid_o,
  output mini_core_pkg::retire_t  retire_o,
  output logic                    alert_o
);

  logic                      fetch_valid;
  mini_core_pkg::fetch_pkt_t fetch_pkt;
  logic                      dec_valid;
  mini_core_pkg::dec_pkt_t   dec_pkt;

  core_fetch #(
    .BootAddr (BootAddr)
  ) fetch_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .paddr_o        (paddr_o),
    .prdata_i       (prdata_i),
    .pready_i       (pready_i),
    .pslverr_i      (pslverr_i),
    .fetch_valid_o  (fetch_valid),
    .fetch_o        (fetch_pkt)
  );

  core_decode decode_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_valid_i (fetch_valid),
    .fetch_i       (fetch_pkt),
    .dec_valid_o   (dec_valid),
    .dec_o         (dec_pkt)
  );

  core_execute execute_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .dec_valid_i    (dec_valid),
    .dec_i          (dec_pkt),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .alert_o        (alert_o)
  );

endmodule

// File: core_tb_props.sv
// Bound assertions for the mini core
// APB requester protocol in fetch, retire order and alert in execute

module core_tb_props (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   psel_i,
  input logic                   penable_i,
  input mini_core_pkg::word_t   paddr_i,
  input logic                   pready_i,
  input logic                   retire_valid_i,
  input mini_core_pkg::retire_t retire_i,
  input logic                   alert_i
);

  mini_core_pkg::order_t next_order;

  always @(posedge clk_i) begin
    if (rst_i) begin
      next_order <= '0;
    end else if (retire_valid_i) begin
      next_order <= next_order + 16'd1;
    end
  end

  // Access phase only after one setup cycle
  assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(penable_i) |-> $past(psel_i && !penable_i))
    else $error("penable rose without a preceding setup phase");

  assert property (@(posedge clk_i) disable iff (rst_i)
    (psel_i && !(penable_i && pready_i)) |=> $stable(paddr_i))
    else $error("paddr changed before the transfer completed");

  assert property (@(posedge clk_i) disable iff (rst_i)
    retire_valid_i |-> (retire_i.order == next_order))
    else $error("retire order skipped or repeated a number");

  assert property (@(posedge clk_i) disable iff (rst_i)
    alert_i |-> (retire_valid_i && retire_i.trap))
    else $error("alert raised without a trap record");

endmodule

bind core_fetch core_tb_props fetch_props (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .psel_i         (psel_o),
  .penable_i      (penable_o),
  .paddr_i        (paddr_o),
  .pready_i       (pready_i),
  .retire_valid_i (1'b0),
  .retire_i       ('0),
  .alert_i        (1'b0)
);

bind core_execute core_tb_props execute_props (
  .clk_i          (clk_i),
  .rst_i          (rst_i),
  .psel_i         (1'b0),
  .penable_i      (1'b0),
  .paddr_i        ('0),
  .pready_i       (1'b0),
  .retire_valid_i (retire_valid_o),
  .retire_i       (retire_o),
  .alert_i        (alert_o)
);

// File: core_tb_top.sv
// Testbench for the mini core
// APB memory model, reference instruction model, retire comparator, timeout

module core_tb_top;

  localparam int NumWords = 200;
  localparam mini_core_pkg::word_t BootAddr = 32'h0000_0000;
  // Word 37 answers with a slave error
  localparam mini_core_pkg::word_t ErrAddr = BootAddr + 32'd148;
  localparam int CycleLimit = NumWords * 8 + 100;

  logic clk;
  logic rst_i;
  logic fetch_enable_i;
  logic psel_o;
  logic penable_o;
  logic pready_i;
  logic pslverr_i;
  logic retire_valid_o;
  logic alert_o;
  mini_core_pkg::word_t   paddr_o;
  mini_core_pkg::word_t   prdata_i;
  mini_core_pkg::retire_t retire_o;

  mini_core_pkg::word_t   mem [NumWords];
  mini_core_pkg::word_t   model_regs [32];
  mini_core_pkg::order_t  model_order;
  mini_core_pkg::retire_t exp_q [$];
  int                     comp_q [$];
  logic [31:0]            lfsr_q;
  int cyc;
  int xfer_cnt;
  int wait_left;
  int retired;
  int checks;
  int errors;

  mini_core_top #(
    .BootAddr (BootAddr)
  ) dut_i (
    .clk_i          (clk),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .psel_o         (psel_o),
    .penable_o      (penable_o),
    .paddr_o        (paddr_o),
    .prdata_i       (prdata_i),
    .pready_i       (pready_i),
    .pslverr_i      (pslverr_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .alert_o        (alert_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic mini_core_pkg::word_t build_word();
    logic [3:0]  sel;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [9:0]  f;
    logic [2:0]  f3;
    logic [31:0] t;
    mini_core_pkg::word_t w;
    sel = take_bits(4);
    rd  = take_bits(5);
    rs1 = take_bits(5);
    rs2 = take_bits(5);
    if (sel == 4'd15) begin
      // Opcode 1111111 is outside the subset
      t = take_bits(25);
      w = {t[24:0], 7'b1111111};
    end else if (sel < 4'd6) begin
      case (take_bits(3) % 5)
        0:       f = {7'b0000000, 3'b000};
        1:       f = {7'b0100000, 3'b000};
        2:       f = {7'b0000000, 3'b111};
        3:       f = {7'b0000000, 3'b110};
        default: f = {7'b0000000, 3'b100};
      endcase
      w = {f[9:3], rs2, rs1, f[2:0], rd, 7'b0110011};
    end else if (sel < 4'd12) begin
      t = take_bits(14);
      case (t[13:12])
        2'd0:    f3 = 3'b000;
        2'd1:    f3 = 3'b111;
        2'd2:    f3 = 3'b110;
        default: f3 = 3'b100;
      endcase
      w = {t[11:0], rs1, f3, rd, 7'b0010011};
    end else begin
      t = take_bits(20);
      w = {t[19:0], rd, 7'b0110111};
    end
    return w;
  endfunction

  // Instruction set model with its own register array
  function automatic mini_core_pkg::retire_t model_step(input mini_core_pkg::word_t pc,
                                                        input mini_core_pkg::word_t insn,
                                                        input logic err);
    mini_core_pkg::retire_t r;
    mini_core_pkg::word_t a;
    mini_core_pkg::word_t b;
    mini_core_pkg::word_t res;
    logic legal;
    a = model_regs[insn[19:15]];
    b = model_regs[insn[24:20]];
    res = '0;
    legal = 1'b1;
    case (insn[6:0])
      7'b0110011: begin
        case ({insn[31:25], insn[14:12]})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_111: res = a & b;
          10'b0000000_110: res = a | b;
          10'b0000000_100: res = a ^ b;
          default:         legal = 1'b0;
        endcase
      end
      7'b0010011: begin
        b = {{20{insn[31]}}, insn[31:20]};
        case (insn[14:12])
          3'b000:  res = a + b;
          3'b111:  res = a & b;
          3'b110:  res = a | b;
          3'b100:  res = a ^ b;
          default: legal = 1'b0;
        endcase
      end
      7'b0110111: res = {insn[31:12], 12'h000};
      default:    legal = 1'b0;
    endcase
    r.order = model_order;
    r.pc = pc;
    r.insn = insn;
    r.trap = err || !legal;
    r.rd_addr = r.trap ? 5'd0 : insn[11:7];
    r.rd_wdata = (r.trap || insn[11:7] == 5'd0) ? 32'd0 : res;
    if (!r.trap && insn[11:7] != 5'd0) begin
      model_regs[insn[11:7]] = res;
    end
    model_order = model_order + 16'd1;
    return r;
  endfunction

  task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic present_word();
    if (xfer_cnt >= NumWords) begin
      errors++;
      $display("Core fetched past the end of the program at transfer %0d", xfer_cnt);
    end
    pready_i  <= 1'b1;
    prdata_i  <= mem[xfer_cnt % NumWords];
    pslverr_i <= (BootAddr + 32'(4 * xfer_cnt)) == ErrAddr;
  endtask

  // APB memory with 0 to 3 wait states per transfer
  always @(posedge clk) begin : apb_memory
    logic [31:0] w;
    if (rst_i) begin
      pready_i  <= 1'b0;
      pslverr_i <= 1'b0;
      prdata_i  <= '0;
      wait_left <= 0;
      xfer_cnt  <= 0;
    end else if (psel_o && penable_o && pready_i) begin
      exp_q.push_back(model_step(BootAddr + 32'(4 * xfer_cnt), mem[xfer_cnt % NumWords],
                                 (BootAddr + 32'(4 * xfer_cnt)) == ErrAddr));
      // Number of this completion edge
      comp_q.push_back(cyc + 1);
      xfer_cnt <= xfer_cnt + 1;
      if (xfer_cnt + 1 == NumWords - 1) begin
        fetch_enable_i <= 1'b0;
      end
      pready_i  <= 1'b0;
      pslverr_i <= 1'b0;
    end else if (psel_o && !penable_o) begin
      w = take_bits(2);
      wait_left <= w;
      if (w == 0) begin
        present_word();
      end
    end else if (psel_o && penable_o) begin
      wait_left <= wait_left - 1;
      if (wait_left == 1) begin
        present_word();
      end
    end
  end

  always @(negedge clk) begin : retire_compare
    mini_core_pkg::retire_t exp_rec;
    if (!rst_i) begin
      if (!fetch_enable_i && xfer_cnt == 0) begin
        compare("idle_psel", 0, psel_o);
        compare("idle_retire", 0, retire_valid_o);
        compare("idle_alert", 0, alert_o);
      end
      if (psel_o && !penable_o) begin
        compare("paddr", BootAddr + 32'(4 * xfer_cnt), paddr_o);
      end
      if (retire_valid_o) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Retire record %0d arrived with no fetched instruction", retire_o.order);
        end else begin
          exp_rec = exp_q.pop_front();
          compare("retire", exp_rec, retire_o);
          compare("alert", exp_rec.trap, alert_o);
          // Fetch register loads on the completion edge itself
          compare("latency", comp_q.pop_front() + 2, cyc);
        end
        retired++;
      end else begin
        compare("alert_idle", 0, alert_o);
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == CycleLimit) begin
      $display("Timeout after %0d cycles with %0d of %0d retired", cyc, retired, NumWords);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    rst_i = 1'b1;
    fetch_enable_i = 1'b0;
    prdata_i = '0;
    pready_i = 1'b0;
    pslverr_i = 1'b0;
    lfsr_q = 32'hbcb4;
    cyc = 0;
    retired = 0;
    checks = 0;
    errors = 0;
    model_order = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < NumWords; i++) begin
      mem[i] = build_word();
    end
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;
    // Idle a few cycles before enabling fetch
    repeat (3) @(posedge clk);
    fetch_enable_i <= 1'b1;
    wait (retired == NumWords);
    repeat (4) @(posedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d fetched instructions never retired", exp_q.size());
    end
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
mini_core_pkg.sv
core_fetch.sv
core_decode.sv
core_execute.sv
mini_core_top.sv
core_tb_props.sv
core_tb_top.sv
